// File: common/ooo_pkg.sv
package ooo_pkg;

    // Datapath and register file sizes
    localparam int XLEN      = 32;
    localparam int NUM_AREGS = 32;
    localparam int NUM_PREGS = 64;                  // Tags 0..31 start mapped, 32..63 start free

    typedef logic [XLEN-1:0]              word_t;   // Register value
    typedef logic [$clog2(NUM_AREGS)-1:0] areg_t;   // Architectural register number
    typedef logic [$clog2(NUM_PREGS)-1:0] preg_t;   // Physical tag, tag 0 is x0

    // ALU operations known to the core
    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_nop                                      // Unsupported encoding, result is zero
    } alu_op_t;

    // Recognised major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // ADDI
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // ADD, SUB

endpackage

// File: logic/inst_decode.sv
`timescale 1ns/1ps

module inst_decode import ooo_pkg::*; (
    input  word_t   instr,
    output areg_t   rs1,
    output areg_t   rs2,
    output areg_t   rd,
    output word_t   imm,
    output logic    use_imm,
    output alu_op_t op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Unused sources read tag 0, which is always ready
    always_comb begin
        op      = op_nop;                           // Anything unknown commits as a write to x0
        use_imm = 1'b0;
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        imm     = {{(XLEN-12){instr[31]}}, instr[31:20]};  // I-type immediate, sign extended
        if (opcode == OPC_OP_IMM && funct3 == 3'b000) begin
            op      = op_add;                       // ADDI
            use_imm = 1'b1;
            rs1     = instr[19:15];
            rd      = instr[11:7];
        end else if (opcode == OPC_OP && funct3 == 3'b000) begin
            case (funct7)
                7'b0000000: op = op_add;
                7'b0100000: op = op_sub;
                default:    op = op_nop;
            endcase
            if (op != op_nop) begin
                rs1 = instr[19:15];
                rs2 = instr[24:20];
                rd  = instr[11:7];
            end
        end
    end

endmodule

// File: rename/free_list.sv
`timescale 1ns/1ps

module free_list import ooo_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  alloc,
    input  logic  release_valid,
    input  preg_t release_tag,
    output logic  empty,
    output preg_t alloc_tag
);

    // At most every tag above the architectural set is free at once
    localparam int DEPTH = NUM_PREGS - NUM_AREGS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    preg_t            queue [DEPTH];
    logic [PTR_W-1:0] head;                         // Next tag handed out
    logic [PTR_W-1:0] tail;                         // Slot for the next returned tag
    logic [CNT_W-1:0] count;

    assign empty     = (count == '0);
    assign alloc_tag = queue[head];                 // Valid whenever not empty

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(DEPTH);
            for (int i = 0; i < DEPTH; i++) begin
                queue[i] <= preg_t'(NUM_AREGS + i); // Starts with tags 32..63
            end
        end else begin
            if (alloc) head <= head + 1'b1;
            if (release_valid) begin
                queue[tail] <= release_tag;
                tail        <= tail + 1'b1;
            end
            count <= count + CNT_W'(release_valid) - CNT_W'(alloc);  // Both may happen
        end
    end

    // Rename must stall before the list runs dry
    assert property (@(posedge clk) disable iff (reset) alloc |-> !empty)
        else $error("free list allocated while empty");

    // Tag 0 belongs to x0 for good and never returns from retirement
    assert property (@(posedge clk) disable iff (reset) release_valid |-> release_tag != '0)
        else $error("free list got tag 0 back");

endmodule

// File: rename/rename_table.sv
`timescale 1ns/1ps

module rename_table import ooo_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  areg_t rs1,
    input  areg_t rs2,
    input  areg_t rd,
    input  logic  rename_en,
    input  preg_t new_tag,
    output preg_t src1_tag,
    output preg_t src2_tag,
    output preg_t old_tag
);

    preg_t map_q [NUM_AREGS];                       // Current tag of each architectural register

    // Lookups see the map before this instruction's own update
    assign src1_tag = map_q[rs1];
    assign src2_tag = map_q[rs2];
    assign old_tag  = map_q[rd];                    // Freed when this instruction retires

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_AREGS; i++) begin
                map_q[i] <= preg_t'(i);             // Identity map out of reset
            end
        end else if (rename_en && rd != '0) begin
            map_q[rd] <= new_tag;                   // x0 stays on tag 0
        end
    end

endmodule

// File: logic/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile import ooo_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  preg_t rd_tag1,                          // Rename lookups, ready bits only
    input  preg_t rd_tag2,
    input  preg_t issue_tag1,                       // Operand reads at issue
    input  preg_t issue_tag2,
    input  logic  alloc_en,
    input  preg_t alloc_tag,
    input  logic  cdb_valid,
    input  preg_t cdb_tag,
    input  word_t cdb_value,
    input  preg_t commit_tag,
    output word_t rd_data1,
    output word_t rd_data2,
    output logic  ready1,
    output logic  ready2,
    output word_t commit_data
);

    word_t                regs [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready_q;
    logic                 cdb_wr;

    assign cdb_wr = cdb_valid && cdb_tag != '0;     // Tag 0 is hardwired zero

    // Result on the bus this cycle, not yet in the array
    function automatic logic bus_hit(preg_t tag);
        return cdb_wr && cdb_tag == tag;
    endfunction

    // Ready as seen by a source entering the reservation station
    assign ready1 = ready_q[rd_tag1] || bus_hit(rd_tag1);
    assign ready2 = ready_q[rd_tag2] || bus_hit(rd_tag2);

    // Issue reads bypass the bus so a woken entry issues at once
    assign rd_data1 = bus_hit(issue_tag1) ? cdb_value : regs[issue_tag1];
    assign rd_data2 = bus_hit(issue_tag2) ? cdb_value : regs[issue_tag2];

    assign commit_data = regs[commit_tag];          // Head is done, value already written

    // Architectural state starts at zero, so values are cleared too
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready_q <= '1;
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alloc_en) ready_q[alloc_tag] <= 1'b0;   // Pending until broadcast
            if (cdb_wr) begin
                regs[cdb_tag]    <= cdb_value;
                ready_q[cdb_tag] <= 1'b1;
            end
        end
    end

endmodule

// File: issue/reservation_station.sv
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; #(
    parameter int RS_DEPTH = 8
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    insert,
    input  alu_op_t op,
    input  preg_t   src1_tag,
    input  preg_t   src2_tag,
    input  logic    src1_ready,
    input  logic    src2_ready,
    input  logic    use_imm,
    input  word_t   imm,
    input  preg_t   dest_tag,
    input  logic    cdb_valid,
    input  preg_t   cdb_tag,
    output logic    full,
    output logic    issue_valid,
    output alu_op_t issue_op,
    output preg_t   issue_src1_tag,
    output preg_t   issue_src2_tag,
    output logic    issue_use_imm,
    output word_t   issue_imm,
    output preg_t   issue_dest_tag
);

    localparam int IDX_W = $clog2(RS_DEPTH);
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    // Collapsing queue where entry 0 is the oldest and live entries sit below count
    alu_op_t             e_op   [RS_DEPTH];
    preg_t               e_tag1 [RS_DEPTH];
    preg_t               e_tag2 [RS_DEPTH];
    word_t               e_imm  [RS_DEPTH];
    preg_t               e_dest [RS_DEPTH];
    logic [RS_DEPTH-1:0] e_rdy1;
    logic [RS_DEPTH-1:0] e_rdy2;
    logic [RS_DEPTH-1:0] e_use_imm;
    logic [RS_DEPTH-1:0] rdy1_now;                  // Ready bits including this cycle's bus
    logic [RS_DEPTH-1:0] rdy2_now;
    logic [CNT_W-1:0]    count;
    logic [CNT_W-1:0]    ins_idx;                   // Slot after the issued entry closes up
    logic [IDX_W-1:0]    sel;

    // Scan from the top so the lowest ready index wins
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            rdy1_now[i] = e_rdy1[i] || (cdb_valid && cdb_tag == e_tag1[i]);
            rdy2_now[i] = e_rdy2[i] || (cdb_valid && cdb_tag == e_tag2[i]);
            if (i < int'(count) && rdy1_now[i] && rdy2_now[i]) begin
                issue_valid = 1'b1;
                sel         = IDX_W'(i);
            end
        end
    end

    assign ins_idx = count - CNT_W'(issue_valid);
    assign full    = (count == CNT_W'(RS_DEPTH));

    assign issue_op       = e_op[sel];
    assign issue_src1_tag = e_tag1[sel];
    assign issue_src2_tag = e_tag2[sel];
    assign issue_use_imm  = e_use_imm[sel];
    assign issue_imm      = e_imm[sel];
    assign issue_dest_tag = e_dest[sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) count <= '0;
        else       count <= count + CNT_W'(insert) - CNT_W'(issue_valid);
    end

    // Entry contents are only meaningful below count
    always_ff @(posedge clk) begin
        int nxt;
        for (int i = 0; i < RS_DEPTH; i++) begin
            nxt = (i < RS_DEPTH - 1) ? i + 1 : i;
            if (insert && CNT_W'(i) == ins_idx) begin
                e_op[i]      <= op;                 // New youngest entry
                e_tag1[i]    <= src1_tag;
                e_tag2[i]    <= src2_tag;
                e_rdy1[i]    <= src1_ready;
                e_rdy2[i]    <= src2_ready;
                e_use_imm[i] <= use_imm;
                e_imm[i]     <= imm;
                e_dest[i]    <= dest_tag;
            end else if (issue_valid && i >= int'(sel)) begin
                e_op[i]      <= e_op[nxt];          // Close the gap and keep age order
                e_tag1[i]    <= e_tag1[nxt];
                e_tag2[i]    <= e_tag2[nxt];
                e_rdy1[i]    <= rdy1_now[nxt];
                e_rdy2[i]    <= rdy2_now[nxt];
                e_use_imm[i] <= e_use_imm[nxt];
                e_imm[i]     <= e_imm[nxt];
                e_dest[i]    <= e_dest[nxt];
            end else begin
                e_rdy1[i] <= rdy1_now[i];           // Wakeup in place
                e_rdy2[i] <= rdy2_now[i];
            end
        end
    end

    // An issued entry leaves at the next edge and never issues twice
    assert property (@(posedge clk) disable iff (reset)
        issue_valid |=> !(issue_valid && issue_dest_tag == $past(issue_dest_tag)))
        else $error("reservation station issued the same entry twice");

endmodule

// File: logic/alu_exec.sv
`timescale 1ns/1ps

module alu_exec import ooo_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    issue_valid,
    input  alu_op_t issue_op,
    input  word_t   src1_data,
    input  word_t   src2_data,
    input  word_t   imm,
    input  logic    use_imm,
    input  preg_t   dest_tag,
    output logic    cdb_valid,
    output preg_t   cdb_tag,
    output word_t   cdb_value
);

    word_t opnd_b;
    word_t result;

    assign opnd_b = use_imm ? imm : src2_data;      // ADDI takes the immediate

    always_comb begin
        case (issue_op)
            op_add:  result = src1_data + opnd_b;
            op_sub:  result = src1_data - opnd_b;
            default: result = '0;
        endcase
    end

    // Broadcast one cycle after issue
    always_ff @(posedge clk or posedge reset) begin
        if (reset) cdb_valid <= 1'b0;
        else       cdb_valid <= issue_valid;        // Single-cycle pulse
    end

    always_ff @(posedge clk) begin
        cdb_tag   <= dest_tag;
        cdb_value <= result;
    end

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  alloc,
    input  areg_t rd,
    input  preg_t dest_tag,
    input  preg_t old_tag,
    input  logic  cdb_valid,
    input  preg_t cdb_tag,
    input  word_t commit_data,
    output logic  full,
    output logic  commit_valid,
    output areg_t commit_rd,
    output word_t commit_value,
    output preg_t commit_tag,
    output logic  release_valid,
    output preg_t release_tag
);

    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    areg_t                e_rd   [ROB_DEPTH];
    preg_t                e_dest [ROB_DEPTH];
    preg_t                e_old  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    logic [PTR_W-1:0]     head;                     // Oldest in program order
    logic [PTR_W-1:0]     tail;
    logic [CNT_W-1:0]     count;
    logic                 retire;

    assign retire     = (count != '0) && done_q[head];
    assign full       = (count == CNT_W'(ROB_DEPTH));
    assign commit_tag = e_dest[head];               // Value read from the register file

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            done_q        <= '0;
            commit_valid  <= 1'b0;
            release_valid <= 1'b0;
        end else begin
            commit_valid  <= retire;
            release_valid <= retire && e_old[head] != '0;   // x0 has nothing to free
            if (cdb_valid) begin
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    if (e_dest[i] == cdb_tag) done_q[i] <= 1'b1;  // Tags are unique in flight
                end
            end
            if (alloc) begin
                done_q[tail] <= (rd == '0);         // Nothing to execute for x0
                tail         <= tail + 1'b1;
            end
            if (retire) head <= head + 1'b1;
            count <= count + CNT_W'(alloc) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            e_rd[tail]   <= rd;
            e_dest[tail] <= dest_tag;
            e_old[tail]  <= old_tag;
        end
        commit_rd    <= e_rd[head];
        commit_value <= commit_data;
        release_tag  <= e_old[head];
    end

    // Decode must hold back instructions once the window is full
    assert property (@(posedge clk) disable iff (reset) alloc |-> !full)
        else $error("reorder buffer allocated while full");

endmodule

// File: logic/ooo_core.sv
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; #(
    parameter int RS_DEPTH  = 8,
    parameter int ROB_DEPTH = 16
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  instr_valid,
    input  word_t instr,
    output logic  instr_ready,
    output logic  commit_valid,
    output areg_t commit_rd,
    output word_t commit_value
);

    // Decode
    areg_t   dec_rs1;
    areg_t   dec_rs2;
    areg_t   dec_rd;
    word_t   dec_imm;
    logic    dec_use_imm;
    alu_op_t dec_op;

    // Rename
    logic    fl_empty;
    preg_t   fl_alloc_tag;
    preg_t   src1_tag;
    preg_t   src2_tag;
    preg_t   old_tag;
    logic    src1_ready;
    logic    src2_ready;
    logic    accept;
    logic    has_dest;
    logic    alloc;
    preg_t   dest_tag;

    // Issue and execute
    logic    rs_full;
    logic    issue_valid;
    alu_op_t issue_op;
    preg_t   issue_src1_tag;
    preg_t   issue_src2_tag;
    logic    issue_use_imm;
    word_t   issue_imm;
    preg_t   issue_dest_tag;
    word_t   opnd1;
    word_t   opnd2;
    logic    cdb_valid;
    preg_t   cdb_tag;
    word_t   cdb_value;

    // Retirement
    logic    rob_full;
    preg_t   commit_tag;
    word_t   commit_data;
    logic    release_valid;
    preg_t   release_tag;

    assign has_dest    = (dec_rd != '0);
    assign instr_ready = !rs_full && !rob_full && !(fl_empty && has_dest);  // Only back-pressure
    assign accept      = instr_valid && instr_ready;
    assign alloc       = accept && has_dest;        // x0 writers skip the free list and RS
    assign dest_tag    = has_dest ? fl_alloc_tag : '0;

    inst_decode u_inst_decode (
        .instr   (instr),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .rd      (dec_rd),
        .imm     (dec_imm),
        .use_imm (dec_use_imm),
        .op      (dec_op)
    );

    free_list u_free_list (
        .clk           (clk),
        .reset         (reset),
        .alloc         (alloc),
        .release_valid (release_valid),
        .release_tag   (release_tag),
        .empty         (fl_empty),
        .alloc_tag     (fl_alloc_tag)
    );

    rename_table u_rename_table (
        .clk       (clk),
        .reset     (reset),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .rename_en (accept),
        .new_tag   (fl_alloc_tag),
        .src1_tag  (src1_tag),
        .src2_tag  (src2_tag),
        .old_tag   (old_tag)
    );

    phys_regfile u_phys_regfile (
        .clk         (clk),
        .reset       (reset),
        .rd_tag1     (src1_tag),
        .rd_tag2     (src2_tag),
        .issue_tag1  (issue_src1_tag),
        .issue_tag2  (issue_src2_tag),
        .alloc_en    (alloc),
        .alloc_tag   (fl_alloc_tag),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .commit_tag  (commit_tag),
        .rd_data1    (opnd1),
        .rd_data2    (opnd2),
        .ready1      (src1_ready),
        .ready2      (src2_ready),
        .commit_data (commit_data)
    );

    reservation_station #(
        .RS_DEPTH (RS_DEPTH)
    ) u_reservation_station (
        .clk            (clk),
        .reset          (reset),
        .insert         (alloc),
        .op             (dec_op),
        .src1_tag       (src1_tag),
        .src2_tag       (src2_tag),
        .src1_ready     (src1_ready),
        .src2_ready     (src2_ready),
        .use_imm        (dec_use_imm),
        .imm            (dec_imm),
        .dest_tag       (dest_tag),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .full           (rs_full),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_src1_tag (issue_src1_tag),
        .issue_src2_tag (issue_src2_tag),
        .issue_use_imm  (issue_use_imm),
        .issue_imm      (issue_imm),
        .issue_dest_tag (issue_dest_tag)
    );

    alu_exec u_alu_exec (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .src1_data   (opnd1),
        .src2_data   (opnd2),
        .imm         (issue_imm),
        .use_imm     (issue_use_imm),
        .dest_tag    (issue_dest_tag),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_reorder_buffer (
        .clk           (clk),
        .reset         (reset),
        .alloc         (accept),                    // Every accepted instruction commits
        .rd            (dec_rd),
        .dest_tag      (dest_tag),
        .old_tag       (old_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .commit_data   (commit_data),
        .full          (rob_full),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .commit_tag    (commit_tag),
        .release_valid (release_valid),
        .release_tag   (release_tag)
    );

endmodule

// File: testbench/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core import ooo_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        instr_valid;
    word_t       instr;
    logic        instr_ready;
    logic        commit_valid;
    areg_t       commit_rd;
    word_t       commit_value;

    word_t       model_regs [NUM_AREGS];            // Architectural state in program order
    areg_t       exp_rd [$];                        // Expected commits, oldest first
    word_t       exp_val [$];
    logic [31:0] lfsr;
    int          errors;
    int          n_sent;
    int          n_commits;
    int          n_tests;
    int          cycles;

    ooo_core #(
        .RS_DEPTH  (8),
        .ROB_DEPTH (16)
    ) u_ooo_core (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    always #10 clk = ~clk;                          // 20 ns period

    // Run limit grows with the number of instructions sent
    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * n_sent + 200) begin
            $display("Timeout after %0d cycles, %0d commits never arrived", cycles, exp_rd.size());
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_areg(areg_t got, areg_t exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Commit outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        if (!reset && commit_valid) begin
            n_commits++;
            if (exp_rd.size() == 0) begin
                $display("Commit of x%0d at %0t with no instruction outstanding", commit_rd, $time);
                errors++;
            end else begin
                check_areg(commit_rd, exp_rd.pop_front(), "commit rd");
                check_word(commit_value, exp_val.pop_front(), "commit value");
            end
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic word_t enc_itype(areg_t rd, areg_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OPC_OP_IMM};  // ADDI
    endfunction

    function automatic word_t enc_rtype(logic [6:0] funct7, areg_t rd, areg_t rs1, areg_t rs2);
        return {funct7, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    // Hold the instruction until the core takes it
    task automatic send(word_t word);
        n_sent++;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        #1;                                         // Ready follows the new rd
        while (!instr_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);                             // Accepted here
    endtask

    task automatic expect_commit(areg_t rd, word_t value);
        exp_rd.push_back(rd);
        exp_val.push_back(rd == '0 ? '0 : value);   // x0 always reads zero
        if (rd != '0) model_regs[rd] = value;
    endtask

    task automatic do_addi(areg_t rd, areg_t rs1, logic [11:0] imm);
        expect_commit(rd, model_regs[rs1] + {{20{imm[11]}}, imm});
        send(enc_itype(rd, rs1, imm));
    endtask

    task automatic do_rr(logic sub, areg_t rd, areg_t rs1, areg_t rs2);
        expect_commit(rd, sub ? model_regs[rs1] - model_regs[rs2]
                              : model_regs[rs1] + model_regs[rs2]);
        send(enc_rtype(sub ? 7'b0100000 : 7'b0000000, rd, rs1, rs2));
    endtask

    task automatic do_other(word_t word);
        expect_commit('0, '0);                      // Retires as a write to x0
        send(word);
    endtask

    // Stop driving and wait for every expected commit
    task automatic drain();
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_rd.size() != 0) @(negedge clk);
    endtask

    task automatic finish_test(string name, int err0);
        n_tests++;
        $display("%s finished with %0d errors", name, errors - err0);
    endtask

    task automatic test_reset_addi();
        int err0;
        err0 = errors;
        #1;
        check_bit(commit_valid, 1'b0, "commit_valid after reset");
        check_bit(instr_ready, 1'b1, "instr_ready after reset");
        for (int i = 1; i <= 10; i++) begin
            do_addi(areg_t'(i), '0, 12'(i * 211 - 900));  // Mixed signs
        end
        drain();
        finish_test("reset and independent ADDI", err0);
    endtask

    task automatic test_dependent_chain();
        int err0;
        err0 = errors;
        do_addi(5'd1, 5'd0, 12'd5);
        do_rr(1'b0, 5'd2, 5'd1, 5'd1);
        do_rr(1'b1, 5'd3, 5'd2, 5'd1);
        do_rr(1'b0, 5'd1, 5'd3, 5'd2);              // x1 overwritten while readers wait
        do_rr(1'b1, 5'd1, 5'd1, 5'd3);
        do_rr(1'b0, 5'd2, 5'd1, 5'd1);
        do_addi(5'd2, 5'd2, 12'hff9);               // Negative immediate
        do_rr(1'b1, 5'd3, 5'd3, 5'd2);
        do_rr(1'b0, 5'd1, 5'd1, 5'd3);
        do_addi(5'd1, 5'd1, 12'h7ff);
        do_rr(1'b1, 5'd4, 5'd3, 5'd1);
        drain();
        finish_test("dependent ADD/SUB chain", err0);
    endtask

    task automatic test_x0_writes();
        int err0;
        err0 = errors;
        do_addi(5'd5, 5'd0, 12'd77);
        do_addi(5'd0, 5'd5, 12'h123);
        do_rr(1'b0, 5'd0, 5'd5, 5'd5);
        do_rr(1'b0, 5'd6, 5'd0, 5'd5);              // Reads x0 after writes to it
        do_rr(1'b1, 5'd7, 5'd0, 5'd0);
        do_addi(5'd8, 5'd0, 12'hfff);
        do_other(32'h0000_0073);                    // ECALL
        do_other(32'h0220_81b3);                    // MUL x3, rd field ignored
        do_other(32'h0010_a093);                    // SLTI x1
        do_rr(1'b0, 5'd9, 5'd0, 5'd8);
        do_rr(1'b0, 5'd10, 5'd3, 5'd1);             // x1 and x3 kept their values
        drain();
        finish_test("x0 writes and unsupported encodings", err0);
    endtask

    // Each instruction reads the previous destination
    task automatic test_burst_reuse();
        int err0;
        err0 = errors;
        for (int i = 0; i < 100; i++) begin
            if (i % 3 == 2) begin
                do_rr(1'b1, areg_t'(i % 31 + 1), areg_t'((i + 30) % 31 + 1),
                      areg_t'((i + 29) % 31 + 1));
            end else begin
                do_addi(areg_t'(i % 31 + 1), areg_t'((i + 30) % 31 + 1), 12'(i * 13));
            end
        end
        drain();
        finish_test("burst of 100 with tag reuse", err0);
    endtask

    task automatic test_random_mix();
        int          err0;
        logic [1:0]  kind;
        areg_t       rd;
        areg_t       rs1;
        areg_t       rs2;
        logic [11:0] imm;
        err0 = errors;
        for (int i = 0; i < 200; i++) begin
            kind = 2'(lfsr_bits(2));
            rd   = areg_t'(lfsr_bits(5));
            rs1  = areg_t'(lfsr_bits(5));
            rs2  = areg_t'(lfsr_bits(5));
            imm  = 12'(lfsr_bits(12));
            if (kind[1]) do_addi(rd, rs1, imm);     // Half ADDI
            else         do_rr(kind[0], rd, rs1, rs2);
        end
        drain();
        finish_test("random ADD/SUB/ADDI mix", err0);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'h7222_b01e;
        errors      = 0;
        n_sent      = 0;
        n_commits   = 0;
        n_tests     = 0;
        cycles      = 0;
        for (int i = 0; i < NUM_AREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_addi();
        test_dependent_chain();
        test_x0_writes();
        test_burst_reuse();
        test_random_mix();
        repeat (5) @(negedge clk);                  // Any stray commit shows up here
        $display("%0d tests, %0d instructions, %0d commits, %0d errors",
                 n_tests, n_sent, n_commits, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/ooo_pkg.sv
logic/inst_decode.sv
rename/free_list.sv
rename/rename_table.sv
logic/phys_regfile.sv
issue/reservation_station.sv
logic/alu_exec.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
testbench/tb_ooo_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ooo_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_ooo_core -Mdir obj_dir -o sim_tb_ooo_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_ooo_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
